/* design/lc3Pkg.sv */
// shared LC-3 definitions
// widths, opcodes, FSM state type
// bus source, ALU function and mux select types
`default_nettype none

package lc3Pkg;

    // data path sizing
    localparam int wordWidth = 16; // data and address width
    localparam int regCount = 8; // general purpose registers
    localparam int regIdxWidth = 3;

    // opcode field IR[15:12]
    localparam logic [3:0] opBr = 4'b0000;
    localparam logic [3:0] opAdd = 4'b0001;
    localparam logic [3:0] opLd = 4'b0010;
    localparam logic [3:0] opSt = 4'b0011;
    localparam logic [3:0] opJsr = 4'b0100; // IR[11] picks JSR or JSRR
    localparam logic [3:0] opAnd = 4'b0101;
    localparam logic [3:0] opLdr = 4'b0110;
    localparam logic [3:0] opStr = 4'b0111;
    localparam logic [3:0] opNot = 4'b1001;
    localparam logic [3:0] opJmp = 4'b1100; // RET is JMP R7
    localparam logic [3:0] opLea = 4'b1110;

    // FSM states, encoding left to synthesis
    typedef enum logic [4:0] {
        start,
        fetch0, fetch1, fetch2,
        decode,
        aluOp0, // ADD, AND, NOT
        br0,
        ld0, ld1, ld2,
        st0, st1, st2,
        ldr0, ldr1, ldr2,
        str0, str1, str2,
        lea0,
        jmp0,
        jsr0,
        jsrr0
    } lc3State;

    // which source drives the bus
    typedef enum logic [2:0] {
        busNone, // bus idles at zero
        busPc,
        busAddr, // address adder result
        busMdr,
        busAlu
    } busSrc;

    typedef enum logic [1:0] {
        aluPass, // srcA straight through
        aluAdd,
        aluAnd,
        aluNot
    } aluOpSel;

    // PC input select
    typedef enum logic [1:0] {
        pcInc,
        pcAddr,
        pcBus
    } pcSel;

    // offset into the address adder
    typedef enum logic [1:0] {
        offZero,
        off6, // IR[5:0]
        off9, // IR[8:0]
        off11 // IR[10:0]
    } addr2Sel;

endpackage

`default_nettype wire

/* design/lc3RegFile.sv */
// general register file
// async clear, two combinational reads, one write, debug view
`timescale 1ns/1ps
`default_nettype none

module lc3RegFile #(
    parameter int regNum = lc3Pkg::regCount,
    parameter int dataWidth = lc3Pkg::wordWidth,
    localparam int idxWidth = $clog2(regNum)
) (
    input logic clk,
    input logic reset,
    input logic we,
    input logic [idxWidth-1:0] writeIdx,
    input logic [idxWidth-1:0] readIdxA,
    input logic [idxWidth-1:0] readIdxB,
    input logic [dataWidth-1:0] writeData,
    output logic [dataWidth-1:0] readDataA,
    output logic [dataWidth-1:0] readDataB,
    output logic [regNum-1:0][dataWidth-1:0] regView
);

    logic [regNum-1:0][dataWidth-1:0] regs;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            regs <= '0; // all registers cleared
        end
        else if (we)
        begin
            regs[writeIdx] <= writeData;
        end
    end

    // reads see old value during a write
    assign readDataA = regs[readIdxA];
    assign readDataB = regs[readIdxB];

    assign regView = regs; // r0..r7 for observation

endmodule

`default_nettype wire

/* design/lc3Control.sv */
// LC-3 control unit
// fetch/decode/execute FSM, Moore outputs per state
// assertions on store strobe and flag inputs
`timescale 1ns/1ps
`default_nettype none

module lc3Control (
    input logic clk,
    input logic reset,
    input logic [lc3Pkg::wordWidth-1:0] ir,
    input logic n,
    input logic z,
    input logic p,
    output lc3Pkg::aluOpSel aluOp,
    output logic [lc3Pkg::regIdxWidth-1:0] sr1,
    output logic [lc3Pkg::regIdxWidth-1:0] sr2,
    output logic [lc3Pkg::regIdxWidth-1:0] dr,
    output lc3Pkg::pcSel pcSelect,
    output logic addr1FromReg,
    output lc3Pkg::addr2Sel addr2Select,
    output lc3Pkg::busSrc busSource,
    output logic regWe,
    output logic flagWe,
    output logic ldPc,
    output logic ldIr,
    output logic ldMar,
    output logic ldMdr,
    output logic mdrFromMem,
    output logic memWe
);
    import lc3Pkg::*;

    lc3State state;
    lc3State nextState;
    lc3State decodedState; // execute state picked in decode
    aluOpSel decodedAlu;
    logic [3:0] opcode;
    logic branchTaken;

    assign opcode = ir[15:12];
    assign branchTaken = (n && ir[11]) || (z && ir[10]) || (p && ir[9]); // nzp mask vs flags

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= start;
        else
            state <= nextState;
    end

    // opcode to first execute state
    always_comb
    begin
        case (opcode)
            opAdd, opAnd, opNot: decodedState = aluOp0;
            opBr: decodedState = br0;
            opLd: decodedState = ld0;
            opSt: decodedState = st0;
            opLdr: decodedState = ldr0;
            opStr: decodedState = str0;
            opLea: decodedState = lea0;
            opJmp: decodedState = jmp0;
            opJsr: decodedState = ir[11] ? jsr0 : jsrr0;
            default: decodedState = fetch0; // unknown opcode returns to fetch
        endcase
    end

    always_comb
    begin
        case (state)
            start: nextState = fetch0;
            fetch0: nextState = fetch1;
            fetch1: nextState = fetch2;
            fetch2: nextState = decode;
            decode: nextState = decodedState;
            ld0: nextState = ld1;
            ld1: nextState = ld2;
            st0: nextState = st1;
            st1: nextState = st2;
            ldr0: nextState = ldr1;
            ldr1: nextState = ldr2;
            str0: nextState = str1;
            str1: nextState = str2;
            default: nextState = fetch0; // last execute state of every instruction
        endcase
    end

    // ALU function straight from opcode
    always_comb
    begin
        case (opcode)
            opAnd: decodedAlu = aluAnd;
            opNot: decodedAlu = aluNot;
            default: decodedAlu = aluAdd;
        endcase
    end

    // multi-bit selects
    always_comb
    begin
        aluOp = aluPass; // st1/str1 rely on pass
        pcSelect = pcAddr; // only fetch1 increments
        addr2Select = offZero; // JMP and JSRR use base alone
        busSource = busNone;
        case (state)
            fetch0: busSource = busPc;
            fetch1: pcSelect = pcInc;
            fetch2: busSource = busMdr;
            aluOp0:
            begin
                aluOp = decodedAlu;
                busSource = busAlu;
            end
            br0: addr2Select = off9;
            ld0, st0, lea0:
            begin
                addr2Select = off9; // PC relative
                busSource = busAddr;
            end
            ldr0, str0:
            begin
                addr2Select = off6; // base plus offset
                busSource = busAddr;
            end
            ld2, ldr2: busSource = busMdr;
            st1, str1: busSource = busAlu;
            jsr0:
            begin
                addr2Select = off11;
                busSource = busPc; // return address to r7
            end
            jsrr0: busSource = busPc;
            default: busSource = busNone;
        endcase
    end

    // register indices from IR fields
    assign sr1 = (state inside {st1, str1}) ? ir[11:9] : ir[8:6]; // store source or base
    assign sr2 = ir[2:0];
    assign dr = (state inside {jsr0, jsrr0}) ? {lc3Pkg::regIdxWidth{1'b1}} : ir[11:9]; // r7 link

    assign addr1FromReg = state inside {ldr0, str0, jmp0, jsrr0};
    assign regWe = state inside {aluOp0, ld2, ldr2, lea0, jsr0, jsrr0};
    assign flagWe = state inside {aluOp0, ld2, ldr2, lea0};
    assign ldPc = (state inside {fetch1, jmp0, jsr0, jsrr0}) || (state == br0 && branchTaken);
    assign ldIr = (state == fetch2);
    assign ldMar = state inside {fetch0, ld0, st0, ldr0, str0};
    assign ldMdr = state inside {fetch1, ld1, ldr1, st1, str1};
    assign mdrFromMem = state inside {fetch1, ld1, ldr1}; // else MDR takes the bus
    assign memWe = state inside {st2, str2};

    // store strobe follows an MDR load from the bus and lasts one cycle
    memWeAfterMdr: assert property (@(posedge clk) disable iff (reset)
        memWe |-> $past(ldMdr && !mdrFromMem) ##1 !memWe);

    // branch test expects at most one flag set
    flagsAtMostOne: assert property (@(posedge clk) disable iff (reset)
        $onehot0({n, z, p}));

endmodule

`default_nettype wire

/* design/lc3Datapath.sv */
// LC-3 datapath
// IR, PC, MAR, MDR, ALU, address adder, bus mux, NZP flags
// holds the register file, assertions on MAR and IR loads
`timescale 1ns/1ps
`default_nettype none

module lc3Datapath #(
    parameter int regNum = lc3Pkg::regCount,
    parameter int dataWidth = lc3Pkg::wordWidth
) (
    input logic clk,
    input logic reset,
    input logic [dataWidth-1:0] memOut,
    input lc3Pkg::aluOpSel aluOp,
    input logic [lc3Pkg::regIdxWidth-1:0] sr1,
    input logic [lc3Pkg::regIdxWidth-1:0] sr2,
    input logic [lc3Pkg::regIdxWidth-1:0] dr,
    input lc3Pkg::pcSel pcSelect,
    input logic addr1FromReg,
    input lc3Pkg::addr2Sel addr2Select,
    input lc3Pkg::busSrc busSource,
    input logic regWe,
    input logic flagWe,
    input logic ldPc,
    input logic ldIr,
    input logic ldMar,
    input logic ldMdr,
    input logic mdrFromMem,
    output logic [dataWidth-1:0] ir,
    output logic [dataWidth-1:0] pc,
    output logic [dataWidth-1:0] mar,
    output logic [dataWidth-1:0] mdr,
    output logic n,
    output logic z,
    output logic p,
    output logic [regNum-1:0][dataWidth-1:0] regView
);
    import lc3Pkg::*;

    logic [dataWidth-1:0] busValue;
    logic [dataWidth-1:0] srcA; // sr1 read port
    logic [dataWidth-1:0] srcB; // sr2 read port
    logic [dataWidth-1:0] operandB; // srcB or imm5
    logic [dataWidth-1:0] aluOut;
    logic [dataWidth-1:0] addrBase;
    logic [dataWidth-1:0] addrOffset;
    logic [dataWidth-1:0] addrSum;
    logic [dataWidth-1:0] pcNext;

    lc3RegFile #(
        .regNum(regNum),
        .dataWidth(dataWidth)
    ) regFile (
        .clk(clk),
        .reset(reset),
        .we(regWe),
        .writeIdx(dr),
        .readIdxA(sr1),
        .readIdxB(sr2),
        .writeData(busValue), // results always arrive over the bus
        .readDataA(srcA),
        .readDataB(srcB),
        .regView(regView)
    );

    // IR[5] picks the immediate form
    assign operandB = ir[5] ? {{(dataWidth-5){ir[4]}}, ir[4:0]} : srcB;

    always_comb
    begin
        case (aluOp)
            aluAdd: aluOut = srcA + operandB;
            aluAnd: aluOut = srcA & operandB;
            aluNot: aluOut = ~srcA;
            default: aluOut = srcA; // pass for stores
        endcase
    end

    // address adder
    assign addrBase = addr1FromReg ? srcA : pc;

    always_comb
    begin
        case (addr2Select)
            off6: addrOffset = {{(dataWidth-6){ir[5]}}, ir[5:0]};
            off9: addrOffset = {{(dataWidth-9){ir[8]}}, ir[8:0]};
            off11: addrOffset = {{(dataWidth-11){ir[10]}}, ir[10:0]};
            default: addrOffset = '0;
        endcase
    end

    assign addrSum = addrBase + addrOffset;

    always_comb
    begin
        case (pcSelect)
            pcInc: pcNext = pc + 1'b1;
            pcAddr: pcNext = addrSum;
            default: pcNext = busValue;
        endcase
    end

    // single bus mux replaces the tri-state bus
    always_comb
    begin
        case (busSource)
            busPc: busValue = pc;
            busAddr: busValue = addrSum;
            busMdr: busValue = mdr;
            busAlu: busValue = aluOut;
            default: busValue = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pc <= '0;
            ir <= '0;
            mar <= '0;
            mdr <= '0;
        end
        else
        begin
            if (ldPc)
                pc <= pcNext;
            if (ldIr)
                ir <= busValue;
            if (ldMar)
                mar <= busValue;
            if (ldMdr)
                mdr <= mdrFromMem ? memOut : busValue; // load data or store data
        end
    end

    // condition codes from the value on the bus
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            n <= 1'b0;
            z <= 1'b0;
            p <= 1'b0;
        end
        else if (flagWe)
        begin
            n <= busValue[dataWidth-1];
            z <= (busValue == '0);
            p <= !busValue[dataWidth-1] && (busValue != '0);
        end
    end

    // MAR only takes the PC or an adder result
    marFromAddress: assert property (@(posedge clk) disable iff (reset)
        ldMar |-> busSource inside {busPc, busAddr});

    // instruction fetch only takes memory data
    irFromMdr: assert property (@(posedge clk) disable iff (reset)
        ldIr |-> busSource == busMdr);

endmodule

`default_nettype wire

/* design/lc3Top.sv */
// LC-3 processor top level
// control unit plus datapath, single cycle memory port
`timescale 1ns/1ps
`default_nettype none

module lc3Top #(
    parameter int regNum = lc3Pkg::regCount,
    parameter int dataWidth = lc3Pkg::wordWidth
) (
    input logic clk,
    input logic reset,
    input logic [dataWidth-1:0] memOut, // read data for mar, same cycle
    output logic memWe,
    output logic [dataWidth-1:0] mar,
    output logic [dataWidth-1:0] mdr,
    output logic [dataWidth-1:0] pc,
    output logic n,
    output logic z,
    output logic p,
    output logic [regNum-1:0][dataWidth-1:0] regView
);
    import lc3Pkg::*;

    logic [dataWidth-1:0] ir;
    aluOpSel aluOp;
    logic [regIdxWidth-1:0] sr1;
    logic [regIdxWidth-1:0] sr2;
    logic [regIdxWidth-1:0] dr;
    pcSel pcSelect;
    addr2Sel addr2Select;
    busSrc busSource;
    logic addr1FromReg;
    logic regWe;
    logic flagWe;
    logic ldPc;
    logic ldIr;
    logic ldMar;
    logic ldMdr;
    logic mdrFromMem;

    lc3Control control (.*); // memWe goes straight to memory

    lc3Datapath #(.regNum(regNum), .dataWidth(dataWidth)) datapath (.*);

endmodule

`default_nettype wire

/* verif/tbClock.sv */
// testbench clock and reset source
// free running clock, reset held for the first cycles
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int halfPeriod = 50, // 100 ns period
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial
    begin
        reset <= 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0; // released on a falling edge
    end

endmodule

`default_nettype wire

/* verif/lc3Tb.sv */
// LC-3 testbench with 64K word memory model and test program
// instruction level reference model, register/flag/PC checks
// store strobe and fetch timing checks, timeout and summary
`timescale 1ns/1ps
`default_nettype none

module lc3Tb;
    import lc3Pkg::*;

    localparam int resetCycles = 8;
    localparam int memWords = 65536;
    localparam int dataBase = 16'h0040; // random data words
    localparam int dataWords = 32;
    localparam logic [15:0] haltAddr = 16'd34; // BRnzp #-1 ends the program
    localparam int instrBudget = 48; // executed instructions plus spare room
    localparam int cycleLimit = instrBudget * 7 + resetCycles + 56; // 400 cycles
    localparam int randomSeed = 13;

    logic clk;
    logic reset;
    logic [15:0] memOut;
    logic memWe;
    logic [15:0] mar;
    logic [15:0] mdr;
    logic [15:0] pc;
    logic n;
    logic z;
    logic p;
    logic [regCount-1:0][wordWidth-1:0] regView;

    logic [15:0] mem [memWords];
    logic imageReady;

    // reference model state
    logic [15:0] modelMem [memWords];
    logic [15:0] modelReg [regCount];
    logic [15:0] modelPc;
    logic modelN;
    logic modelZ;
    logic modelP;
    int instLen; // cycles of the running instruction
    logic storing;
    logic [15:0] storeAddr;
    logic [15:0] storeData;
    int errorCount;
    int pulseErrors = 0;

    tbClock #(.halfPeriod(50), .resetCycles(resetCycles)) clockGen (.clk(clk), .reset(reset));

    lc3Top #(
        .regNum(regCount),
        .dataWidth(wordWidth)
    ) dut (
        .clk(clk),
        .reset(reset),
        .memOut(memOut),
        .memWe(memWe),
        .mar(mar),
        .mdr(mdr),
        .pc(pc),
        .n(n),
        .z(z),
        .p(p),
        .regView(regView)
    );

    assign memOut = mem[mar]; // same cycle read

    // instruction field packers
    function automatic logic [15:0] regOperands(logic [3:0] op, int d, int s1, int s2);
        return {op, 3'(d), 3'(s1), 3'b000, 3'(s2)};
    endfunction

    function automatic logic [15:0] immOperand(logic [3:0] op, int d, int s1, int imm);
        return {op, 3'(d), 3'(s1), 1'b1, 5'(imm)};
    endfunction

    function automatic logic [15:0] pcOffset(logic [3:0] op, int r, int off);
        return {op, 3'(r), 9'(off)}; // r is the nzp mask for BR
    endfunction

    function automatic logic [15:0] baseOffset(logic [3:0] op, int r, int base, int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    initial
    begin : memoryModel
        imageReady = 1'b0;
        void'($urandom(randomSeed)); // single seed for the run
        for (int a = 0; a < memWords; a++)
            mem[a] = (16'(a) * 16'h2f1d) ^ 16'hb6a3;
        for (int a = dataBase; a < dataBase + dataWords; a++)
            mem[a] = 16'($urandom);
        mem[0] = pcOffset(opLea, 1, 63); // r1 = 0x40
        mem[1] = pcOffset(opLd, 2, 63); // from 0x41
        mem[2] = baseOffset(opLdr, 3, 1, 5);
        mem[3] = regOperands(opAdd, 4, 2, 3);
        mem[4] = immOperand(opAdd, 5, 4, -7);
        mem[5] = regOperands(opAnd, 6, 2, 3);
        mem[6] = immOperand(opAnd, 0, 5, 0); // zero result
        mem[7] = pcOffset(opBr, 2, 1); // BRz taken
        mem[8] = immOperand(opAdd, 0, 0, 1);
        mem[9] = pcOffset(opBr, 1, 1); // BRp not taken
        mem[10] = baseOffset(opNot, 6, 6, 63);
        mem[11] = immOperand(opAdd, 0, 0, -3);
        mem[12] = pcOffset(opBr, 4, 1); // BRn taken
        mem[13] = immOperand(opAdd, 0, 0, 15);
        mem[14] = pcOffset(opBr, 3, 2); // BRzp not taken
        mem[15] = pcOffset(opSt, 4, 64); // to 0x50
        mem[16] = baseOffset(opStr, 6, 1, 17); // to 0x51
        mem[17] = pcOffset(opLd, 7, 62); // reads 0x50 back
        mem[18] = baseOffset(opLdr, 5, 1, 17);
        mem[19] = {opJsr, 1'b1, 11'd3}; // JSR to 23
        mem[20] = pcOffset(opLea, 3, 4); // r3 = 25
        mem[21] = baseOffset(opJsr, 0, 3, 0); // JSRR r3
        mem[22] = pcOffset(opBr, 7, 4); // on to 27
        mem[23] = immOperand(opAdd, 2, 2, 4);
        mem[24] = baseOffset(opJmp, 0, 7, 0); // RET
        mem[25] = baseOffset(opStr, 2, 1, 18); // to 0x52
        mem[26] = baseOffset(opJmp, 0, 7, 0);
        mem[27] = pcOffset(opLea, 4, 2);
        mem[28] = baseOffset(opJmp, 0, 4, 0); // JMP r4 to 30
        mem[29] = immOperand(opAdd, 0, 0, 1);
        mem[30] = immOperand(opAdd, 6, 7, 15);
        mem[31] = pcOffset(opBr, 0, 5); // empty mask
        mem[32] = pcOffset(opBr, 5, 1); // BRnp taken on positive r6
        mem[33] = baseOffset(opNot, 0, 0, 63);
        mem[34] = pcOffset(opBr, 7, -1);
        imageReady = 1'b1;
        forever
        begin
            @(posedge clk);
            if (memWe)
                mem[mar] = mdr; // no memory read at a store edge
        end
    end

    task automatic compareWord(input string name, input logic [15:0] expected,
            input logic [15:0] actual);
        assert (actual === expected)
        else
        begin
            errorCount++;
            $display("Fail %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic compareArchState();
        compareWord("pc", modelPc, pc);
        compareWord("nzp", {13'd0, modelN, modelZ, modelP}, {13'd0, n, z, p});
        for (int i = 0; i < regCount; i++)
            compareWord($sformatf("r%0d", i), modelReg[i], regView[i]);
    endtask

    // runs one instruction at modelPc by the ISA rules
    task automatic stepModel();
        logic [15:0] inst;
        logic [15:0] nextPc;
        logic [15:0] base;
        logic [15:0] operand;
        logic [15:0] off6;
        logic [15:0] off9;
        logic [15:0] target;
        logic [15:0] result;
        logic writesReg;
        inst = modelMem[modelPc];
        nextPc = modelPc + 16'd1;
        base = modelReg[inst[8:6]];
        operand = inst[5] ? {{11{inst[4]}}, inst[4:0]} : modelReg[inst[2:0]];
        off6 = {{10{inst[5]}}, inst[5:0]};
        off9 = {{7{inst[8]}}, inst[8:0]};
        result = 16'd0;
        writesReg = inst[15:12] inside {opAdd, opAnd, opNot, opLd, opLdr, opLea};
        storing = 1'b0;
        instLen = 5;
        case (inst[15:12])
            opAdd: result = base + operand;
            opAnd: result = base & operand;
            opNot: result = ~base;
            opLea: result = nextPc + off9;
            opLd:
            begin
                result = modelMem[nextPc + off9];
                instLen = 7;
            end
            opLdr:
            begin
                result = modelMem[base + off6];
                instLen = 7;
            end
            opSt, opStr:
            begin
                storing = 1'b1;
                storeAddr = (inst[15:12] == opSt) ? nextPc + off9 : base + off6;
                storeData = modelReg[inst[11:9]]; // source in IR[11:9]
                modelMem[storeAddr] = storeData;
                instLen = 7;
            end
            opBr:
                if ((inst[11] && modelN) || (inst[10] && modelZ) || (inst[9] && modelP))
                    nextPc = nextPc + off9;
            opJmp: nextPc = base;
            opJsr:
            begin
                target = inst[11] ? nextPc + {{5{inst[10]}}, inst[10:0]} : base;
                modelReg[7] = nextPc; // target read before the link write
                nextPc = target;
            end
            default: instLen = 4; // unknown opcode returns to fetch
        endcase
        if (writesReg)
        begin
            modelReg[inst[11:9]] = result;
            modelN = $signed(result) < 0; // sign of the written value
            modelZ = result == 16'd0;
            modelP = $signed(result) > 0;
        end
        modelPc = nextPc;
    endtask

    // a store strobe lasts exactly one cycle
    storeStrobeSingle: assert property (@(posedge clk) disable iff (reset) memWe |=> !memWe)
    else
    begin
        pulseErrors++;
        $display("memWe stayed high for more than one cycle at %0t", $time);
    end

    initial
    begin : runChecks
        int cycles;
        int pos; // cycle within the instruction from fetch0
        logic [15:0] fetchAddr;
        logic weExpected;
        logic done;
        logic timedOut;
        errorCount = 0;
        cycles = 0;
        pos = 0;
        instLen = 0; // first boundary right after reset
        storing = 1'b0;
        fetchAddr = 16'd0;
        done = 1'b0;
        timedOut = 1'b0;
        modelPc = 16'd0;
        modelN = 1'b0;
        modelZ = 1'b0;
        modelP = 1'b0;
        for (int i = 0; i < regCount; i++)
            modelReg[i] = 16'd0;
        wait (imageReady);
        for (int a = 0; a < memWords; a++)
            modelMem[a] = mem[a];
        @(negedge clk);
        cycles++;
        while (reset)
        begin
            compareWord("memWe", 16'd0, {15'd0, memWe});
            compareArchState(); // model still all zero
            @(negedge clk);
            cycles++;
        end
        while (!done && !timedOut)
        begin
            if (pos == instLen)
            begin
                compareArchState(); // result of the previous instruction
                if (modelPc == haltAddr)
                    done = 1'b1;
                else
                begin
                    fetchAddr = modelPc;
                    stepModel();
                    pos = 0;
                end
            end
            if (!done)
            begin
                weExpected = storing && (pos == 6); // st2 or str2
                compareWord("memWe", {15'd0, weExpected}, {15'd0, memWe});
                if (weExpected)
                begin
                    compareWord("mar", storeAddr, mar);
                    compareWord("mdr", storeData, mdr);
                end
                if (pos == 1)
                begin
                    compareWord("mar", fetchAddr, mar); // fetch0 just loaded mar
                    compareWord("pc", fetchAddr, pc);
                end
                if (pos == 2)
                    compareWord("pc", fetchAddr + 16'd1, pc); // incremented in fetch1
                @(negedge clk);
                cycles++;
                pos++;
                timedOut = (cycles >= cycleLimit);
            end
        end
        if (timedOut)
            $display("timeout, program did not reach its halt loop in %0d cycles", cycles);
        $display("checks done, %0d value errors, %0d strobe errors", errorCount, pulseErrors);
        if (!timedOut && errorCount == 0 && pulseErrors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/lc3Pkg.sv
design/lc3RegFile.sv
design/lc3Control.sv
design/lc3Datapath.sv
design/lc3Top.sv
verif/tbClock.sv
verif/lc3Tb.sv

/* runSim.sh */
#!/bin/sh
# Verilator build and run of the LC-3 testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lc3Tb -f vlog.f -o lc3Sim \
    && ./obj_dir/lc3Sim > sim.log 2>&1 \
    || echo "build or simulation error" >> sim.log

cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
